// ==== dwc_pkg.sv ====
// Bus widths, AXI field types, burst/response/state enums and address helper functions
`default_nettype none

package dwc_pkg;

  // Default data widths of the narrow master and the wide slave
  localparam int unsigned narrow_data_width = 32;
  localparam int unsigned wide_data_width   = 128;

  localparam int unsigned addr_width = 32;
  localparam int unsigned id_width   = 4;

  // Bit index of the modifiable flag in AWCACHE
  localparam int unsigned cache_modifiable = 1;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [7:0]            len_t;
  typedef logic [2:0]            size_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    W_IDLE,
    W_PASSTHROUGH,
    W_INCR_UPSIZE,
    W_ERROR
  } wr_state_e;

  // Clear the address bits below the given beat size
  function automatic addr_t aligned_addr(input addr_t addr, input size_t size);
    return (addr >> size) << size;
  endfunction

  // Address of beat n of an INCR burst
  // Beat 0 keeps the unaligned start address
  function automatic addr_t beat_addr(input addr_t start_addr, input size_t size,
                                      input len_t beat);
    if (beat == '0) begin
      return start_addr;
    end
    return aligned_addr(start_addr, size) + (addr_t'(beat) << size);
  endfunction

endpackage

`default_nettype wire

// ==== beat_if.sv ====
// Interface carrying the current beat position between counter, packer and FSM
`timescale 1ns/1ps
`default_nettype none

interface beat_if #(
  parameter int unsigned WideDataWidth = dwc_pkg::wide_data_width
) ();
  import dwc_pkg::*;

  // Size of one wide beat, used for word boundary detection
  localparam size_t WideSize = size_t'($clog2(WideDataWidth / 8));

  // Burst load from the FSM
  logic  load;
  addr_t load_addr;
  size_t load_size;
  len_t  load_len;

  // Current beat position
  addr_t addr;
  size_t orig_size;
  len_t  remaining;
  logic  last;
  logic  word_done;
  logic  advance;

  modport ctr (
    input  load, load_addr, load_size, load_len, advance,
    output addr, orig_size, remaining, last, word_done
  );

  modport fsm (
    output load, load_addr, load_size, load_len, advance,
    input  remaining, last, word_done
  );

  modport pk (
    input addr, orig_size, advance
  );

endinterface

`default_nettype wire

// ==== beat_counter.sv ====
// Remaining-beat counter and narrow address tracker for the burst in flight
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
  input  logic clk_i,
  input  logic rst_ni,
  beat_if.ctr  bif
);
  import dwc_pkg::*;

  addr_t addr_q;
  size_t size_q;
  len_t  remaining_q;
  addr_t next_addr;

  // Following beats start on a size-aligned address
  assign next_addr = beat_addr(addr_q, size_q, len_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      size_q      <= '0;
      remaining_q <= '0;
    end else if (bif.load) begin
      addr_q      <= bif.load_addr;
      size_q      <= bif.load_size;
      remaining_q <= bif.load_len;
    end else if (bif.advance) begin
      addr_q      <= next_addr;
      remaining_q <= remaining_q - len_t'(1);
    end
  end

  assign bif.addr      = addr_q;
  assign bif.orig_size = size_q;
  assign bif.remaining = remaining_q;
  assign bif.last      = (remaining_q == '0);

  // Word is full once the next beat lands in another wide word
  assign bif.word_done = bif.last ||
                         (aligned_addr(next_addr, bif.WideSize) !=
                          aligned_addr(addr_q, bif.WideSize));

endmodule

`default_nettype wire

// ==== lane_packer.sv ====
// Wide W data and strobe buffer that steers narrow byte lanes into place
`timescale 1ns/1ps
`default_nettype none

module lane_packer #(
  parameter int unsigned NarrowDataWidth = dwc_pkg::narrow_data_width,
  parameter int unsigned WideDataWidth   = dwc_pkg::wide_data_width
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  beat_if.pk                           bif,
  input  logic [NarrowDataWidth-1:0]   w_data_i,
  input  logic [NarrowDataWidth/8-1:0] w_strb_i,
  input  logic                         clear_i,
  output logic [WideDataWidth-1:0]     m_w_data_o,
  output logic [WideDataWidth/8-1:0]   m_w_strb_o
);
  import dwc_pkg::*;

  localparam int unsigned NarrowBytes = NarrowDataWidth / 8;
  localparam int unsigned WideBytes   = WideDataWidth / 8;

  logic [WideDataWidth-1:0]   data_q, data_d;
  logic [WideBytes-1:0]       strb_q, strb_d;

  addr_t       beat_base;
  int unsigned wide_off;
  int unsigned narrow_off;
  int unsigned beat_bytes;

  // Lanes of a beat start at its size-aligned address
  assign beat_base  = aligned_addr(bif.addr, bif.orig_size);
  assign wide_off   = beat_base % WideBytes;
  assign narrow_off = beat_base % NarrowBytes;
  assign beat_bytes = 1 << bif.orig_size;

  always_comb begin
    int unsigned src;
    src    = 0;
    data_d = clear_i ? '0 : data_q;
    strb_d = clear_i ? '0 : strb_q;
    if (bif.advance) begin
      for (int unsigned b = 0; b < WideBytes; b++) begin
        src = b - wide_off + narrow_off;
        // Only the lanes covered by this beat are taken
        if ((b >= wide_off) && (b < wide_off + beat_bytes) && (src < NarrowBytes)) begin
          data_d[8*b +: 8] = w_data_i[8*src +: 8];
          strb_d[b]        = w_strb_i[src];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strb_q <= '0;
    end else begin
      strb_q <= strb_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  assign m_w_data_o = data_q;
  assign m_w_strb_o = strb_q;

endmodule

`default_nettype wire

// ==== wr_upsize_fsm.sv ====
// Write FSM for AW decode, burst conversion, W and AW valid control, B forwarding and error B
`timescale 1ns/1ps
`default_nettype none

module wr_upsize_fsm #(
  parameter int unsigned NarrowDataWidth = dwc_pkg::narrow_data_width,
  parameter int unsigned WideDataWidth   = dwc_pkg::wide_data_width
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  beat_if.fsm                             bif,
  // Narrow AW
  input  logic [dwc_pkg::id_width-1:0]    aw_id_i,
  input  dwc_pkg::addr_t                  aw_addr_i,
  input  dwc_pkg::len_t                   aw_len_i,
  input  dwc_pkg::size_t                  aw_size_i,
  input  dwc_pkg::burst_e                 aw_burst_i,
  input  logic [3:0]                      aw_cache_i,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  // Narrow W control
  input  logic                            w_last_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  // Narrow B
  output logic [dwc_pkg::id_width-1:0]    b_id_o,
  output dwc_pkg::resp_e                  b_resp_o,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  // Wide AW
  output logic [dwc_pkg::id_width-1:0]    m_aw_id_o,
  output dwc_pkg::addr_t                  m_aw_addr_o,
  output dwc_pkg::len_t                   m_aw_len_o,
  output dwc_pkg::size_t                  m_aw_size_o,
  output dwc_pkg::burst_e                 m_aw_burst_o,
  output logic [3:0]                      m_aw_cache_o,
  output logic                            m_aw_valid_o,
  input  logic                            m_aw_ready_i,
  // Wide W control, data comes from the packer
  output logic                            wide_valid_o,
  input  logic                            wide_ready_i,
  output logic                            wide_last_o,
  // Wide B
  input  logic [dwc_pkg::id_width-1:0]    m_b_id_i,
  input  dwc_pkg::resp_e                  m_b_resp_i,
  input  logic                            m_b_valid_i,
  output logic                            m_b_ready_o,
  output logic                            clear_o
);
  import dwc_pkg::*;

  localparam size_t WideSize  = size_t'($clog2(WideDataWidth / 8));
  localparam bit    CanUpsize = WideDataWidth > NarrowDataWidth;

  wr_state_e state_q, state_d;
  logic      aw_valid_q, aw_valid_d;
  logic      wide_valid_q, wide_valid_d;
  logic      wide_last_q, wide_last_d;
  logic      w_done_q, w_done_d;
  logic      err_b_valid_q, err_b_valid_d;

  logic [id_width-1:0] aw_id_q;
  addr_t               aw_addr_q;
  len_t                aw_len_q;
  size_t               aw_size_q;
  burst_e              aw_burst_q;
  logic [3:0]          aw_cache_q;

  logic  aw_accept;
  logic  is_error;
  logic  is_upsize;
  addr_t start_addr;
  addr_t end_addr;
  len_t  wide_len;

  assign aw_ready_o = (state_q == W_IDLE);
  assign aw_accept  = aw_valid_i && aw_ready_o;

  // Multi-beat non-INCR bursts cannot be converted
  assign is_error  = (aw_burst_i != BURST_INCR) && (aw_len_i != '0);
  assign is_upsize = CanUpsize && (aw_burst_i == BURST_INCR) &&
                     aw_cache_i[cache_modifiable] && (aw_len_i != '0);

  // Wide length spans the aligned first and last wide words
  assign start_addr = aligned_addr(aw_addr_i, WideSize);
  assign end_addr   = aligned_addr(beat_addr(aw_addr_i, aw_size_i, aw_len_i), WideSize);
  assign wide_len   = len_t'((end_addr - start_addr) >> WideSize);

  assign bif.load      = aw_accept;
  assign bif.load_addr = aw_addr_i;
  assign bif.load_size = aw_size_i;
  assign bif.load_len  = aw_len_i;
  assign bif.advance   = w_valid_i && w_ready_o;

  always_comb begin
    unique case (state_q)
      W_PASSTHROUGH, W_INCR_UPSIZE:
        w_ready_o = !aw_valid_q && !w_done_q && (!wide_valid_q || wide_ready_i);
      W_ERROR:
        w_ready_o = !err_b_valid_q;
      default:
        w_ready_o = 1'b0;
    endcase
  end

  always_comb begin
    state_d       = state_q;
    aw_valid_d    = aw_valid_q && !m_aw_ready_i;
    wide_valid_d  = wide_valid_q && !wide_ready_i;
    wide_last_d   = wide_last_q;
    w_done_d      = w_done_q;
    err_b_valid_d = err_b_valid_q;
    unique case (state_q)
      W_IDLE: begin
        if (aw_accept) begin
          w_done_d = 1'b0;
          if (is_error) begin
            state_d = W_ERROR;
          end else begin
            aw_valid_d = 1'b1;
            state_d    = is_upsize ? W_INCR_UPSIZE : W_PASSTHROUGH;
          end
        end
      end
      W_PASSTHROUGH, W_INCR_UPSIZE: begin
        if (bif.advance) begin
          w_done_d = bif.last;
          // Passthrough sends every narrow beat as its own wide beat
          if ((state_q == W_PASSTHROUGH) || bif.word_done) begin
            wide_valid_d = 1'b1;
            wide_last_d  = bif.last;
          end
        end
        if (wide_valid_q && wide_ready_i && wide_last_q) begin
          state_d = W_IDLE;
        end
      end
      W_ERROR: begin
        // Stop on WLAST or once the AW length runs out
        if (bif.advance && (w_last_i || (bif.remaining == '0))) begin
          err_b_valid_d = 1'b1;
        end
        if (err_b_valid_q && b_ready_i) begin
          err_b_valid_d = 1'b0;
          state_d       = W_IDLE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= W_IDLE;
      aw_valid_q    <= 1'b0;
      wide_valid_q  <= 1'b0;
      wide_last_q   <= 1'b0;
      w_done_q      <= 1'b0;
      err_b_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      aw_valid_q    <= aw_valid_d;
      wide_valid_q  <= wide_valid_d;
      wide_last_q   <= wide_last_d;
      w_done_q      <= w_done_d;
      err_b_valid_q <= err_b_valid_d;
    end
  end

  // Wide AW fields, converted bursts go out at full wide size
  always_ff @(posedge clk_i) begin
    if (aw_accept) begin
      aw_id_q    <= aw_id_i;
      aw_addr_q  <= aw_addr_i;
      aw_burst_q <= aw_burst_i;
      aw_cache_q <= aw_cache_i;
      aw_len_q   <= is_upsize ? wide_len : aw_len_i;
      aw_size_q  <= is_upsize ? WideSize : aw_size_i;
    end
  end

  assign m_aw_id_o    = aw_id_q;
  assign m_aw_addr_o  = aw_addr_q;
  assign m_aw_len_o   = aw_len_q;
  assign m_aw_size_o  = aw_size_q;
  assign m_aw_burst_o = aw_burst_q;
  assign m_aw_cache_o = aw_cache_q;
  assign m_aw_valid_o = aw_valid_q;

  assign wide_valid_o = wide_valid_q;
  assign wide_last_o  = wide_last_q;

  // Buffer is emptied on every wide handshake and while idle
  assign clear_o = (wide_valid_q && wide_ready_i) || (state_q == W_IDLE);

  always_comb begin
    if (err_b_valid_q) begin
      b_id_o      = aw_id_q;
      b_resp_o    = RESP_SLVERR;
      b_valid_o   = 1'b1;
      m_b_ready_o = 1'b0;
    end else begin
      b_id_o      = m_b_id_i;
      b_resp_o    = m_b_resp_i;
      b_valid_o   = m_b_valid_i;
      m_b_ready_o = b_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== axi_dw_write_upsizer.sv ====
// Top level of the AXI write upsizer joining FSM, beat counter and lane packer
`timescale 1ns/1ps
`default_nettype none

module axi_dw_write_upsizer #(
  parameter int unsigned NarrowDataWidth = dwc_pkg::narrow_data_width,
  parameter int unsigned WideDataWidth   = dwc_pkg::wide_data_width
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Narrow AW
  input  logic [dwc_pkg::id_width-1:0]    aw_id_i,
  input  dwc_pkg::addr_t                  aw_addr_i,
  input  dwc_pkg::len_t                   aw_len_i,
  input  dwc_pkg::size_t                  aw_size_i,
  input  dwc_pkg::burst_e                 aw_burst_i,
  input  logic [3:0]                      aw_cache_i,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  // Narrow W
  input  logic [NarrowDataWidth-1:0]      w_data_i,
  input  logic [NarrowDataWidth/8-1:0]    w_strb_i,
  input  logic                            w_last_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  // Narrow B
  output logic [dwc_pkg::id_width-1:0]    b_id_o,
  output dwc_pkg::resp_e                  b_resp_o,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  // Wide AW
  output logic [dwc_pkg::id_width-1:0]    m_aw_id_o,
  output dwc_pkg::addr_t                  m_aw_addr_o,
  output dwc_pkg::len_t                   m_aw_len_o,
  output dwc_pkg::size_t                  m_aw_size_o,
  output dwc_pkg::burst_e                 m_aw_burst_o,
  output logic [3:0]                      m_aw_cache_o,
  output logic                            m_aw_valid_o,
  input  logic                            m_aw_ready_i,
  // Wide W
  output logic [WideDataWidth-1:0]        m_w_data_o,
  output logic [WideDataWidth/8-1:0]      m_w_strb_o,
  output logic                            m_w_last_o,
  output logic                            m_w_valid_o,
  input  logic                            m_w_ready_i,
  // Wide B
  input  logic [dwc_pkg::id_width-1:0]    m_b_id_i,
  input  dwc_pkg::resp_e                  m_b_resp_i,
  input  logic                            m_b_valid_i,
  output logic                            m_b_ready_o
);

  logic clear;

  beat_if #(
    .WideDataWidth(WideDataWidth)
  ) bif ();

  wr_upsize_fsm #(
    .NarrowDataWidth(NarrowDataWidth),
    .WideDataWidth  (WideDataWidth)
  ) i_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .bif         (bif.fsm),
    .aw_id_i     (aw_id_i),
    .aw_addr_i   (aw_addr_i),
    .aw_len_i    (aw_len_i),
    .aw_size_i   (aw_size_i),
    .aw_burst_i  (aw_burst_i),
    .aw_cache_i  (aw_cache_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .w_last_i    (w_last_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .m_aw_id_o   (m_aw_id_o),
    .m_aw_addr_o (m_aw_addr_o),
    .m_aw_len_o  (m_aw_len_o),
    .m_aw_size_o (m_aw_size_o),
    .m_aw_burst_o(m_aw_burst_o),
    .m_aw_cache_o(m_aw_cache_o),
    .m_aw_valid_o(m_aw_valid_o),
    .m_aw_ready_i(m_aw_ready_i),
    .wide_valid_o(m_w_valid_o),
    .wide_ready_i(m_w_ready_i),
    .wide_last_o (m_w_last_o),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .clear_o     (clear)
  );

  beat_counter i_counter (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .bif   (bif.ctr)
  );

  lane_packer #(
    .NarrowDataWidth(NarrowDataWidth),
    .WideDataWidth  (WideDataWidth)
  ) i_packer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bif       (bif.pk),
    .w_data_i  (w_data_i),
    .w_strb_i  (w_strb_i),
    .clear_i   (clear),
    .m_w_data_o(m_w_data_o),
    .m_w_strb_o(m_w_strb_o)
  );

endmodule

`default_nettype wire

// ==== tb_dw_write_upsizer.sv ====
// Directed testbench for the AXI write upsizer with narrow master driver and wide slave model
`timescale 1ns/1ps
`default_nettype none

module tb_dw_write_upsizer;
  import dwc_pkg::*;

  localparam int NarrowBytes = narrow_data_width / 8;
  localparam int WideBytes   = wide_data_width / 8;
  localparam size_t WideSize = size_t'($clog2(WideBytes));
  // Under 50 narrow beats in all, a few hundred cycles even with back-pressure
  localparam int TimeoutCycles = 2000;

  typedef logic [wide_data_width-1:0]   wdata_t;
  typedef logic [WideBytes-1:0]         wstrb_t;
  typedef logic [narrow_data_width-1:0] ndata_t;
  typedef logic [NarrowBytes-1:0]       nstrb_t;
  typedef logic [id_width-1:0]          id_t;

  logic       clk_i;
  logic       rst_ni;
  id_t        aw_id_i;
  addr_t      aw_addr_i;
  len_t       aw_len_i;
  size_t      aw_size_i;
  burst_e     aw_burst_i;
  logic [3:0] aw_cache_i;
  logic       aw_valid_i;
  logic       aw_ready_o;
  ndata_t     w_data_i;
  nstrb_t     w_strb_i;
  logic       w_last_i;
  logic       w_valid_i;
  logic       w_ready_o;
  id_t        b_id_o;
  resp_e      b_resp_o;
  logic       b_valid_o;
  logic       b_ready_i;
  id_t        m_aw_id_o;
  addr_t      m_aw_addr_o;
  len_t       m_aw_len_o;
  size_t      m_aw_size_o;
  burst_e     m_aw_burst_o;
  logic [3:0] m_aw_cache_o;
  logic       m_aw_valid_o;
  logic       m_aw_ready_i;
  wdata_t     m_w_data_o;
  wstrb_t     m_w_strb_o;
  logic       m_w_last_o;
  logic       m_w_valid_o;
  logic       m_w_ready_i;
  id_t        m_b_id_i;
  resp_e      m_b_resp_i;
  logic       m_b_valid_i;
  logic       m_b_ready_o;

  integer seed = 67470;
  bit     stall_en;
  bit     b_pending;
  id_t    b_id_next;
  int     errors;
  int     checks;
  int     cycle_cnt;

  // Transfers seen by the wide slave
  id_t        rec_aw_id[$];
  addr_t      rec_aw_addr[$];
  len_t       rec_aw_len[$];
  size_t      rec_aw_size[$];
  burst_e     rec_aw_burst[$];
  logic [3:0] rec_aw_cache[$];
  wdata_t     rec_w_data[$];
  wstrb_t     rec_w_strb[$];
  logic       rec_w_last[$];

  // Reference wide beats and the narrow beats of the current burst
  wdata_t exp_data[$];
  wstrb_t exp_strb[$];
  logic   exp_last[$];
  ndata_t beat_data[0:15];
  nstrb_t beat_strb[0:15];

  axi_dw_write_upsizer #(
    .NarrowDataWidth(narrow_data_width),
    .WideDataWidth  (wide_data_width)
  ) uut (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Wide slave, samples handshakes at the falling edge and drives after the rising edge
  always begin : wide_slave
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    @(negedge clk_i);
    aw_hs = rst_ni && m_aw_valid_o && m_aw_ready_i;
    w_hs  = rst_ni && m_w_valid_o && m_w_ready_i;
    b_hs  = rst_ni && m_b_valid_i && m_b_ready_o;
    if (aw_hs) begin
      rec_aw_id.push_back(m_aw_id_o);
      rec_aw_addr.push_back(m_aw_addr_o);
      rec_aw_len.push_back(m_aw_len_o);
      rec_aw_size.push_back(m_aw_size_o);
      rec_aw_burst.push_back(m_aw_burst_o);
      rec_aw_cache.push_back(m_aw_cache_o);
      b_id_next = m_aw_id_o;
    end
    if (w_hs) begin
      rec_w_data.push_back(m_w_data_o);
      rec_w_strb.push_back(m_w_strb_o);
      rec_w_last.push_back(m_w_last_o);
      if (m_w_last_o) begin
        b_pending = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
    m_aw_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    m_w_ready_i  = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    if (b_hs) begin
      m_b_valid_i = 1'b0;
    end
    if (b_pending && !m_b_valid_i) begin
      m_b_valid_i = 1'b1;
      m_b_id_i    = b_id_next;
      m_b_resp_i  = RESP_OKAY;
      b_pending   = 1'b0;
    end
  end

  task automatic check_len(input string what, input len_t got, input len_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_size(input string what, input size_t got, input size_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_burst(input string what, input burst_e got, input burst_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_cache(input string what, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input string what, input id_t got, input id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input resp_e got, input resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Data is compared only on the byte lanes that the expected strobe enables
  task automatic check_data(input string what, input wdata_t got_d, input wstrb_t got_s,
                            input wdata_t exp_d, input wstrb_t exp_s);
    wdata_t mask;
    mask = '0;
    for (int b = 0; b < WideBytes; b++) begin
      mask[8*b +: 8] = {8{exp_s[b]}};
    end
    checks++;
    if ((got_s !== exp_s) || ((got_d & mask) !== (exp_d & mask))) begin
      errors++;
      $display("error %0t: %s data %h strb %h, expected data %h strb %h",
               $time, what, got_d & mask, got_s, exp_d & mask, exp_s);
    end
  endtask

  // Narrow beats with distinct bytes, strobes cover the size-aligned lanes
  task automatic make_beats(input id_t id, input addr_t addr, input len_t len, input size_t size);
    addr_t base;
    int    nbytes;
    nbytes = 1 << size;
    base   = (addr >> size) << size;
    for (int i = 0; i <= int'(len); i++) begin
      beat_data[i] = {4'hA, id, 8'(i), addr[15:0]};
      beat_strb[i] = nstrb_t'(((1 << nbytes) - 1) << (base % NarrowBytes));
      base = base + nbytes;
    end
  endtask

  // Reference wide beats, lanes placed at the beat address within the wide word
  task automatic build_expected(input addr_t addr, input len_t len, input size_t size,
                                input bit upsize);
    addr_t  base;
    int     nbytes;
    int     wb;
    int     nb;
    wdata_t word_d;
    wstrb_t word_s;
    nbytes = 1 << size;
    base   = (addr >> size) << size;
    word_d = '0;
    word_s = '0;
    exp_data.delete();
    exp_strb.delete();
    exp_last.delete();
    for (int i = 0; i <= int'(len); i++) begin
      for (int k = 0; k < nbytes; k++) begin
        wb = (base % WideBytes) + k;
        nb = (base % NarrowBytes) + k;
        word_d[8*wb +: 8] = beat_data[i][8*nb +: 8];
        word_s[wb]        = beat_strb[i][nb];
      end
      // A word closes at a wide boundary, at the end, or after each beat in passthrough
      if (!upsize || (i == int'(len)) || (((base + nbytes) / WideBytes) != (base / WideBytes))) begin
        exp_data.push_back(word_d);
        exp_strb.push_back(word_s);
        exp_last.push_back(i == int'(len));
        word_d = '0;
        word_s = '0;
      end
      base = base + nbytes;
    end
  endtask

  // Narrow master, one AW then all W beats then waits for B
  task automatic run_burst(input id_t id, input addr_t addr, input len_t len, input size_t size,
                           input burst_e burst, input logic [3:0] cache,
                           output id_t got_id, output resp_e got_resp);
    rec_aw_id.delete();
    rec_aw_addr.delete();
    rec_aw_len.delete();
    rec_aw_size.delete();
    rec_aw_burst.delete();
    rec_aw_cache.delete();
    rec_w_data.delete();
    rec_w_strb.delete();
    rec_w_last.delete();
    @(posedge clk_i);
    #1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    aw_size_i  = size;
    aw_burst_i = burst;
    aw_cache_i = cache;
    aw_valid_i = 1'b1;
    @(negedge clk_i);
    while (!aw_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      w_data_i  = beat_data[i];
      w_strb_i  = beat_strb[i];
      w_last_i  = (i == int'(len));
      w_valid_i = 1'b1;
      @(negedge clk_i);
      while (!w_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    @(negedge clk_i);
    while (!b_valid_o) @(negedge clk_i);
    got_id   = b_id_o;
    got_resp = b_resp_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_forwarded(input id_t id, input addr_t addr, input len_t len,
                                 input size_t size, input logic [3:0] cache, input bit upsize);
    id_t   got_id;
    resp_e got_resp;
    int    n;
    make_beats(id, addr, len, size);
    build_expected(addr, len, size, upsize);
    run_burst(id, addr, len, size, BURST_INCR, cache, got_id, got_resp);
    check_count("wide AW count", rec_aw_id.size(), 1);
    if (rec_aw_id.size() > 0) begin
      check_id("wide AW id", rec_aw_id[0], id);
      check_addr("wide AW addr", rec_aw_addr[0], addr);
      check_len("wide AW len", rec_aw_len[0], upsize ? len_t'(exp_data.size() - 1) : len);
      check_size("wide AW size", rec_aw_size[0], upsize ? WideSize : size);
      check_burst("wide AW burst", rec_aw_burst[0], BURST_INCR);
      check_cache("wide AW cache", rec_aw_cache[0], cache);
    end
    check_count("wide W count", rec_w_data.size(), exp_data.size());
    n = (rec_w_data.size() < exp_data.size()) ? rec_w_data.size() : exp_data.size();
    for (int k = 0; k < n; k++) begin
      check_data($sformatf("wide beat %0d", k), rec_w_data[k], rec_w_strb[k],
                 exp_data[k], exp_strb[k]);
      check_bit($sformatf("wide beat %0d last", k), rec_w_last[k], exp_last[k]);
    end
    check_id("B id", got_id, id);
    check_resp("B resp", got_resp, RESP_OKAY);
  endtask

  task automatic check_rejected(input id_t id, input addr_t addr, input burst_e burst);
    id_t   got_id;
    resp_e got_resp;
    make_beats(id, addr, len_t'(3), size_t'(2));
    run_burst(id, addr, len_t'(3), size_t'(2), burst, 4'b0010, got_id, got_resp);
    check_count("wide AW count", rec_aw_id.size(), 0);
    check_count("wide W count", rec_w_data.size(), 0);
    check_id("error B id", got_id, id);
    check_resp("error B resp", got_resp, RESP_SLVERR);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_bit("aw_ready after reset", aw_ready_o, 1'b1);
    check_bit("m_aw_valid after reset", m_aw_valid_o, 1'b0);
    check_bit("m_w_valid after reset", m_w_valid_o, 1'b0);
    check_bit("b_valid after reset", b_valid_o, 1'b0);
  endtask

  task automatic test_upsize();
    check_forwarded(4'h3, 32'h100, len_t'(7), size_t'(2), 4'b0010, 1'b1);
    check_forwarded(4'h5, 32'h108, len_t'(3), size_t'(2), 4'b0011, 1'b1);
  endtask

  task automatic test_passthrough();
    check_forwarded(4'h6, 32'h204, len_t'(3), size_t'(2), 4'b0000, 1'b0);
    check_forwarded(4'h7, 32'h032, len_t'(0), size_t'(1), 4'b0010, 1'b0);
  endtask

  task automatic test_error_bursts();
    check_rejected(4'h9, 32'h300, BURST_WRAP);
    check_rejected(4'hA, 32'h400, BURST_FIXED);
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    check_forwarded(4'hC, 32'h100, len_t'(7), size_t'(2), 4'b0010, 1'b1);
    check_forwarded(4'hD, 32'h108, len_t'(3), size_t'(2), 4'b0011, 1'b1);
    stall_en = 1'b0;
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    aw_id_i     = '0;
    aw_addr_i   = '0;
    aw_len_i    = '0;
    aw_size_i   = '0;
    aw_burst_i  = BURST_INCR;
    aw_cache_i  = '0;
    aw_valid_i  = 1'b0;
    w_data_i    = '0;
    w_strb_i    = '0;
    w_last_i    = 1'b0;
    w_valid_i   = 1'b0;
    b_ready_i   = 1'b1;
    m_aw_ready_i = 1'b1;
    m_w_ready_i = 1'b1;
    m_b_id_i    = '0;
    m_b_resp_i  = RESP_OKAY;
    m_b_valid_i = 1'b0;
    stall_en    = 1'b0;
    b_pending   = 1'b0;
    errors      = 0;
    checks      = 0;
    cycle_cnt   = 0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_state();
    test_upsize();
    test_passthrough();
    test_error_bursts();
    test_backpressure();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
dwc_pkg.sv
beat_if.sv
beat_counter.sv
lane_packer.sv
wr_upsize_fsm.sv
axi_dw_write_upsizer.sv
tb_dw_write_upsizer.sv

// ==== Makefile ====
TOP = tb_dw_write_upsizer

all: run

build:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module axi_dw_write_upsizer

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
